// ==== hw/mips_pkg.sv ====
package mips_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // primary opcodes kept by the core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_t;

    // function field of the special opcode
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_t;

    typedef struct packed {
        opcode_t    op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } inst_r_t;

    typedef struct packed {
        opcode_t     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } inst_i_t;

    // one instruction word, two field layouts
    typedef union packed {
        inst_r_t rtype;
        inst_i_t itype;
    } inst_t;

endpackage

// ==== hw/mips_fetch.sv ====
module mips_fetch #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            br_taken_i,
    input  mips_pkg::word_t br_target_i,
    input  mips_pkg::word_t inst_sram_rdata_i,
    output logic            inst_sram_en_o,
    output mips_pkg::word_t inst_sram_addr_o,
    output logic            dec_valid_o,
    output mips_pkg::word_t dec_pc_o,
    output mips_pkg::inst_t dec_inst_o
);

    mips_pkg::word_t pc;
    logic            en_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q        <= 1'b0;
            pc          <= RESET_PC;
            dec_valid_o <= 1'b0;
        end else begin
            en_q <= 1'b1;
            if (en_q) begin
                // taken branch redirects the next request
                pc <= br_taken_i ? br_target_i : pc + 32'd4;
            end
            // request issued alongside a taken branch is on the wrong path
            dec_valid_o <= en_q & ~br_taken_i;
        end
    end

    // pc of the request in flight
    always_ff @(posedge clk) begin
        dec_pc_o <= pc;
    end

    assign inst_sram_en_o   = en_q;
    assign inst_sram_addr_o = pc;

    // memory word arrives one cycle after the strobe
    assign dec_inst_o = inst_sram_rdata_i;

endmodule

// ==== hw/mips_decode.sv ====
module mips_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  mips_pkg::word_t     pc_i,
    input  mips_pkg::inst_t     inst_i,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    output logic                ex_valid_o,
    output mips_pkg::word_t     ex_pc_o,
    output mips_pkg::alu_op_t   ex_alu_op_o,
    output mips_pkg::branch_t   ex_branch_o,
    output mips_pkg::reg_addr_t ex_rs_addr_o,
    output mips_pkg::reg_addr_t ex_rt_addr_o,
    output mips_pkg::word_t     ex_rs_val_o,
    output mips_pkg::word_t     ex_rt_val_o,
    output mips_pkg::word_t     ex_imm_o,
    output logic                ex_use_imm_o,
    output logic [4:0]          ex_shamt_o,
    output logic                ex_we_o,
    output mips_pkg::reg_addr_t ex_waddr_o
);

    mips_pkg::alu_op_t   alu_op;
    mips_pkg::branch_t   branch;
    mips_pkg::reg_addr_t dst;
    mips_pkg::word_t     imm_ext;
    logic                use_imm;
    logic                sign_ext;
    logic                writes;
    logic                we;

    always_comb begin
        alu_op   = mips_pkg::ALU_ADD;
        branch   = mips_pkg::BR_NONE;
        use_imm  = 1'b1;
        sign_ext = 1'b1;
        writes   = 1'b1;
        dst      = inst_i.itype.rt;
        case (inst_i.itype.op)
            mips_pkg::OP_SPECIAL: begin
                // register format writes rd
                use_imm = 1'b0;
                dst     = inst_i.rtype.rd;
                case (inst_i.rtype.funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  alu_op = mips_pkg::ALU_SRA;
                    default:           writes = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
            mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU;
            mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
            // logic immediates are zero extended
            mips_pkg::OP_ANDI: begin
                alu_op   = mips_pkg::ALU_AND;
                sign_ext = 1'b0;
            end
            mips_pkg::OP_ORI: begin
                alu_op   = mips_pkg::ALU_OR;
                sign_ext = 1'b0;
            end
            mips_pkg::OP_XORI: begin
                alu_op   = mips_pkg::ALU_XOR;
                sign_ext = 1'b0;
            end
            mips_pkg::OP_BEQ: begin
                branch = mips_pkg::BR_EQ;
                writes = 1'b0;
            end
            mips_pkg::OP_BNE: begin
                branch = mips_pkg::BR_NE;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ? {{16{inst_i.itype.imm[15]}}, inst_i.itype.imm}
                              : {16'h0000, inst_i.itype.imm};

    // r0 is never written
    assign we = writes & (dst != '0);

    assign rs_addr_o = inst_i.rtype.rs;
    assign rt_addr_o = inst_i.rtype.rt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o  <= 1'b0;
            ex_we_o     <= 1'b0;
            ex_branch_o <= mips_pkg::BR_NONE;
        end else begin
            ex_valid_o  <= valid_i;
            ex_we_o     <= we;
            ex_branch_o <= valid_i ? branch : mips_pkg::BR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o      <= pc_i;
        ex_alu_op_o  <= alu_op;
        ex_rs_addr_o <= rs_addr_o;
        ex_rt_addr_o <= rt_addr_o;
        ex_rs_val_o  <= rs_data_i;
        ex_rt_val_o  <= rt_data_i;
        ex_imm_o     <= imm_ext;
        ex_use_imm_o <= use_imm;
        ex_shamt_o   <= inst_i.rtype.shamt;
        ex_waddr_o   <= dst;
    end

endmodule

// ==== hw/mips_regfile.sv ====
module mips_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    output mips_pkg::word_t     rdata_a_o,
    output mips_pkg::word_t     rdata_b_o
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < mips_pkg::NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is visible to the reader
    assign rdata_a_o = (we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

// ==== hw/mips_execute.sv ====
module mips_execute (
    input  logic                ex_valid_i,
    input  mips_pkg::word_t     ex_pc_i,
    input  mips_pkg::alu_op_t   ex_alu_op_i,
    input  mips_pkg::branch_t   ex_branch_i,
    input  mips_pkg::reg_addr_t ex_rs_addr_i,
    input  mips_pkg::reg_addr_t ex_rt_addr_i,
    input  mips_pkg::word_t     ex_rs_val_i,
    input  mips_pkg::word_t     ex_rt_val_i,
    input  mips_pkg::word_t     ex_imm_i,
    input  logic                ex_use_imm_i,
    input  logic [4:0]          ex_shamt_i,
    input  logic                ex_we_i,
    input  mips_pkg::reg_addr_t ex_waddr_i,
    input  logic                res_we_i,
    input  mips_pkg::reg_addr_t res_waddr_i,
    input  mips_pkg::word_t     res_wdata_i,
    output logic                br_taken_o,
    output mips_pkg::word_t     br_target_o,
    output logic                comb_valid_o,
    output mips_pkg::word_t     comb_pc_o,
    output logic                comb_we_o,
    output mips_pkg::reg_addr_t comb_waddr_o,
    output mips_pkg::word_t     comb_wdata_o
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t rt_fwd;
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_res;

    // result stage is the only forwarding source, older values come via the regfile
    assign op_a   = (res_we_i && res_waddr_i == ex_rs_addr_i) ? res_wdata_i : ex_rs_val_i;
    assign rt_fwd = (res_we_i && res_waddr_i == ex_rt_addr_i) ? res_wdata_i : ex_rt_val_i;
    assign op_b   = ex_use_imm_i ? ex_imm_i : rt_fwd;

    always_comb begin
        case (ex_alu_op_i)
            mips_pkg::ALU_ADD:  alu_res = op_a + op_b;
            mips_pkg::ALU_SUB:  alu_res = op_a - op_b;
            mips_pkg::ALU_AND:  alu_res = op_a & op_b;
            mips_pkg::ALU_OR:   alu_res = op_a | op_b;
            mips_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            mips_pkg::ALU_NOR:  alu_res = ~(op_a | op_b);
            mips_pkg::ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            mips_pkg::ALU_SLTU: alu_res = {31'd0, op_a < op_b};
            // shifts act on rt by shamt
            mips_pkg::ALU_SLL:  alu_res = op_b << ex_shamt_i;
            mips_pkg::ALU_SRL:  alu_res = op_b >> ex_shamt_i;
            mips_pkg::ALU_SRA:  alu_res = $signed(op_b) >>> ex_shamt_i;
            mips_pkg::ALU_LUI:  alu_res = {op_b[15:0], 16'h0000};
            default:            alu_res = op_a + op_b;
        endcase
    end

    // compare uses rt even though op_b carries the offset
    always_comb begin
        case (ex_branch_i)
            mips_pkg::BR_EQ: br_taken_o = (op_a == rt_fwd);
            mips_pkg::BR_NE: br_taken_o = (op_a != rt_fwd);
            default:         br_taken_o = 1'b0;
        endcase
    end

    // offset is relative to the delay slot
    assign br_target_o = ex_pc_i + 32'd4 + {ex_imm_i[29:0], 2'b00};

    assign comb_valid_o = ex_valid_i;
    assign comb_pc_o    = ex_pc_i;
    assign comb_we_o    = ex_we_i;
    assign comb_waddr_o = ex_waddr_i;
    assign comb_wdata_o = alu_res;

endmodule

// ==== hw/mips_result.sv ====
module mips_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                comb_valid_i,
    input  mips_pkg::word_t     comb_pc_i,
    input  logic                comb_we_i,
    input  mips_pkg::reg_addr_t comb_waddr_i,
    input  mips_pkg::word_t     comb_wdata_i,
    output logic                rf_we_o,
    output mips_pkg::reg_addr_t rf_waddr_o,
    output mips_pkg::word_t     rf_wdata_o,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t     debug_wb_rf_wdata_o
);

    mips_pkg::word_t pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we_o <= 1'b0;
        end else begin
            rf_we_o <= comb_valid_i & comb_we_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_q       <= comb_pc_i;
        rf_waddr_o <= comb_waddr_i;
        rf_wdata_o <= comb_wdata_i;
    end

    // trace reports a full word write as four byte enables
    assign debug_wb_pc_o       = pc_q;
    assign debug_wb_rf_wen_o   = {4{rf_we_o}};
    assign debug_wb_rf_wnum_o  = rf_waddr_o;
    assign debug_wb_rf_wdata_o = rf_wdata_o;

endmodule

// ==== hw/mips_core.sv ====
module mips_core #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::word_t     inst_sram_rdata_i,
    output logic                inst_sram_en_o,
    output mips_pkg::word_t     inst_sram_addr_o,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t     debug_wb_rf_wdata_o
);

    // fetch to decode
    logic                dec_valid;
    mips_pkg::word_t     dec_pc;
    mips_pkg::inst_t     dec_inst;

    // branch redirect
    logic                br_taken;
    mips_pkg::word_t     br_target;

    // register read
    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;

    // decode to execute
    logic                ex_valid;
    mips_pkg::word_t     ex_pc;
    mips_pkg::alu_op_t   ex_alu_op;
    mips_pkg::branch_t   ex_branch;
    mips_pkg::reg_addr_t ex_rs_addr;
    mips_pkg::reg_addr_t ex_rt_addr;
    mips_pkg::word_t     ex_rs_val;
    mips_pkg::word_t     ex_rt_val;
    mips_pkg::word_t     ex_imm;
    logic                ex_use_imm;
    logic [4:0]          ex_shamt;
    logic                ex_we;
    mips_pkg::reg_addr_t ex_waddr;

    // execute to result
    logic                comb_valid;
    mips_pkg::word_t     comb_pc;
    logic                comb_we;
    mips_pkg::reg_addr_t comb_waddr;
    mips_pkg::word_t     comb_wdata;

    // writeback, also the forwarding source
    logic                rf_we;
    mips_pkg::reg_addr_t rf_waddr;
    mips_pkg::word_t     rf_wdata;

    mips_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk               (clk),
        .rst               (rst),
        .br_taken_i        (br_taken),
        .br_target_i       (br_target),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .inst_sram_en_o    (inst_sram_en_o),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .dec_valid_o       (dec_valid),
        .dec_pc_o          (dec_pc),
        .dec_inst_o        (dec_inst)
    );

    mips_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (dec_valid),
        .pc_i         (dec_pc),
        .inst_i       (dec_inst),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .rs_addr_o    (rs_addr),
        .rt_addr_o    (rt_addr),
        .ex_valid_o   (ex_valid),
        .ex_pc_o      (ex_pc),
        .ex_alu_op_o  (ex_alu_op),
        .ex_branch_o  (ex_branch),
        .ex_rs_addr_o (ex_rs_addr),
        .ex_rt_addr_o (ex_rt_addr),
        .ex_rs_val_o  (ex_rs_val),
        .ex_rt_val_o  (ex_rt_val),
        .ex_imm_o     (ex_imm),
        .ex_use_imm_o (ex_use_imm),
        .ex_shamt_o   (ex_shamt),
        .ex_we_o      (ex_we),
        .ex_waddr_o   (ex_waddr)
    );

    mips_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs_addr),
        .raddr_b_i (rt_addr),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data)
    );

    mips_execute u_execute (
        .ex_valid_i   (ex_valid),
        .ex_pc_i      (ex_pc),
        .ex_alu_op_i  (ex_alu_op),
        .ex_branch_i  (ex_branch),
        .ex_rs_addr_i (ex_rs_addr),
        .ex_rt_addr_i (ex_rt_addr),
        .ex_rs_val_i  (ex_rs_val),
        .ex_rt_val_i  (ex_rt_val),
        .ex_imm_i     (ex_imm),
        .ex_use_imm_i (ex_use_imm),
        .ex_shamt_i   (ex_shamt),
        .ex_we_i      (ex_we),
        .ex_waddr_i   (ex_waddr),
        .res_we_i     (rf_we),
        .res_waddr_i  (rf_waddr),
        .res_wdata_i  (rf_wdata),
        .br_taken_o   (br_taken),
        .br_target_o  (br_target),
        .comb_valid_o (comb_valid),
        .comb_pc_o    (comb_pc),
        .comb_we_o    (comb_we),
        .comb_waddr_o (comb_waddr),
        .comb_wdata_o (comb_wdata)
    );

    mips_result u_result (
        .clk                 (clk),
        .rst                 (rst),
        .comb_valid_i        (comb_valid),
        .comb_pc_i           (comb_pc),
        .comb_we_i           (comb_we),
        .comb_waddr_i        (comb_waddr),
        .comb_wdata_i        (comb_wdata),
        .rf_we_o             (rf_we),
        .rf_waddr_o          (rf_waddr),
        .rf_wdata_o          (rf_wdata),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// ==== test/tb_imem.sv ====
module tb_imem #(
    parameter logic [31:0] BASE  = 32'hbfc00000,
    parameter int          DEPTH = 64
) (
    input  logic        clk,
    input  logic        en_i,
    input  logic [31:0] addr_i,
    output logic [31:0] rdata_o
);

    logic [31:0] mem [DEPTH];
    logic [31:0] req_word;

    // opcode 6'h3f is no core instruction, so unused words retire nothing
    function automatic logic [31:0] fill_word(logic [31:0] idx);
        return {6'h3f, idx[25:0] ^ {22'd0, idx[29:26]}};
    endfunction

    function automatic logic [31:0] read_word(logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - BASE) >> 2;
        if (idx < DEPTH) begin
            return mem[idx];
        end
        return fill_word(idx);
    endfunction

    initial begin
        rdata_o  = '0;
        req_word = '0;
    end

    // request taken in one cycle, word presented before the end of the next
    always @(negedge clk) begin
        rdata_o <= req_word;
        if (en_i) begin
            req_word <= read_word(addr_i);
        end
    end

endmodule

// ==== test/tb_mips_core.sv ====
module tb_mips_core;

    localparam logic [31:0] RESET_PC   = 32'hbfc00000;
    localparam int          IMEM_DEPTH = 64;

    // primary opcodes
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_SLTI  = 6'h0a;
    localparam logic [5:0] OPC_SLTIU = 6'h0b;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_XORI  = 6'h0e;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    // special function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    logic        clk;
    logic        rst;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_pc [$];
    logic [4:0]  got_num [$];
    logic [31:0] got_data [$];

    int seed = 32'h3015;
    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_err_base = 0;
    int budget_words = 0;

    tb_clock #(
        .PERIOD (100)
    ) u_clock (
        .clk_o (clk)
    );

    tb_imem #(
        .BASE  (RESET_PC),
        .DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk     (clk),
        .en_i    (inst_sram_en),
        .addr_i  (inst_sram_addr),
        .rdata_o (inst_sram_rdata)
    );

    mips_core #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .inst_sram_rdata_i   (inst_sram_rdata),
        .inst_sram_en_o      (inst_sram_en),
        .inst_sram_addr_o    (inst_sram_addr),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    // trace registers settle after the edge, so record what the last cycle held
    always @(posedge clk) begin
        if (!rst && debug_wb_rf_wen != 4'b0000) begin
            got_pc.push_back(debug_wb_pc);
            got_num.push_back(debug_wb_rf_wnum);
            got_data.push_back(debug_wb_rf_wdata);
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cycles <= 40 * budget_words);
        $display("watchdog expired after %0d cycles, expected retirements never arrived",
                 cycles);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt, logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // instruction that leaves no trace write
    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // instruction expected to retire with a register write
    task automatic emit_expect(input logic [31:0] word, input logic [4:0] num,
                               input logic [31:0] data);
        exp_pc.push_back(RESET_PC + 32'(4 * prog.size()));
        exp_num.push_back(num);
        exp_data.push_back(data);
        prog.push_back(word);
    endtask

    task automatic load_and_reset();
        budget_words += prog.size();
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            if (i < prog.size()) begin
                u_imem.mem[i] = prog[i];
            end else begin
                u_imem.mem[i] = u_imem.fill_word(i);
            end
        end
        got_pc.delete();
        got_num.delete();
        got_data.delete();
        test_err_base = errors;
        repeat (2) begin
            @(negedge clk);
            check("inst_sram_en_o", inst_sram_en, 0);
            check("debug_wb_rf_wen_o", debug_wb_rf_wen, 0);
        end
        rst = 1'b0;
    endtask

    task automatic collect_and_compare(input string name);
        while (got_pc.size() < exp_pc.size()) begin
            @(negedge clk);
        end
        // pipeline is three deep, a few more cycles expose extra writes
        repeat (4) @(negedge clk);
        if (got_pc.size() != exp_pc.size()) begin
            errors++;
            $display("test %s saw %0d register writes on the trace, expected %0d",
                     name, got_pc.size(), exp_pc.size());
        end
        for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
            check($sformatf("debug_wb_pc_o[%0d]", i), got_pc[i], exp_pc[i]);
            check($sformatf("debug_wb_rf_wnum_o[%0d]", i), got_num[i], exp_num[i]);
            check($sformatf("debug_wb_rf_wdata_o[%0d]", i), got_data[i], exp_data[i]);
        end
        tests++;
        $display("test %s finished with %0d errors", name, errors - test_err_base);
        prog.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
    endtask

    task automatic test_reset();
        emit_expect(enc_i(OPC_ADDIU, 1, 0, 16'h1234), 1, 32'h00001234);
        emit_expect(enc_i(OPC_ADDIU, 2, 1, 16'hffff), 2, 32'h00001233);
        load_and_reset();
        // first strobe comes in the cycle after reset is released
        @(negedge clk);
        check("inst_sram_en_o", inst_sram_en, 1);
        check("inst_sram_addr_o", inst_sram_addr, RESET_PC);
        repeat (2) begin
            @(negedge clk);
            check("debug_wb_rf_wen_o", debug_wb_rf_wen, 0);
        end
        @(negedge clk);
        check("debug_wb_rf_wen_o", debug_wb_rf_wen, 4'hf);
        check("debug_wb_pc_o", debug_wb_pc, RESET_PC);
        collect_and_compare("reset");
    endtask

    task automatic test_chains();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] n;
        a = $random(seed);
        b = $random(seed);
        s = a + b;
        d = s - a;
        x = s ^ b;
        y = d & x;
        z = d | y;
        n = ~(z | s);
        emit_expect(enc_i(OPC_LUI, 1, 0, a[31:16]), 1, {a[31:16], 16'h0000});
        emit_expect(enc_i(OPC_ORI, 1, 1, a[15:0]), 1, a);
        emit_expect(enc_i(OPC_LUI, 2, 0, b[31:16]), 2, {b[31:16], 16'h0000});
        emit_expect(enc_i(OPC_ORI, 2, 2, b[15:0]), 2, b);
        emit_expect(enc_r(FN_ADDU, 3, 1, 2, 0), 3, s);
        emit_expect(enc_r(FN_SUBU, 4, 3, 1, 0), 4, d);
        emit_expect(enc_r(FN_XOR, 5, 3, 2, 0), 5, x);
        emit_expect(enc_r(FN_AND, 6, 4, 5, 0), 6, y);
        emit_expect(enc_r(FN_OR, 7, 4, 6, 0), 7, z);
        emit_expect(enc_r(FN_NOR, 8, 7, 3, 0), 8, n);
        emit_expect(enc_r(FN_SLT, 9, 8, 1, 0), 9, ($signed(n) < $signed(a)) ? 32'd1 : 32'd0);
        emit_expect(enc_r(FN_SLTU, 10, 8, 1, 0), 10, (n < a) ? 32'd1 : 32'd0);
        load_and_reset();
        collect_and_compare("dependent chains");
    endtask

    task automatic test_immediates();
        emit_expect(enc_i(OPC_ADDIU, 1, 0, 16'hfff0), 1, 32'hfffffff0);
        emit_expect(enc_i(OPC_ADDIU, 2, 1, 16'h7fff), 2, 32'h00007fef);
        emit_expect(enc_i(OPC_SLTI, 3, 1, 16'hfff8), 3, 32'd1);
        emit_expect(enc_i(OPC_SLTIU, 4, 2, 16'hffff), 4, 32'd1);
        emit_expect(enc_i(OPC_SLTIU, 5, 1, 16'h0001), 5, 32'd0);
        emit_expect(enc_i(OPC_ANDI, 6, 1, 16'h8f0f), 6, 32'h00008f00);
        emit_expect(enc_i(OPC_ORI, 7, 0, 16'h8001), 7, 32'h00008001);
        emit_expect(enc_i(OPC_XORI, 8, 1, 16'hffff), 8, 32'hffff000f);
        emit_expect(enc_i(OPC_LUI, 9, 0, 16'h8765), 9, 32'h87650000);
        load_and_reset();
        collect_and_compare("immediates");
    endtask

    task automatic test_shifts_compares();
        emit_expect(enc_i(OPC_LUI, 1, 0, 16'h8000), 1, 32'h80000000);
        emit_expect(enc_i(OPC_ORI, 1, 1, 16'h00f0), 1, 32'h800000f0);
        emit_expect(enc_r(FN_SLL, 2, 0, 1, 4), 2, 32'h00000f00);
        emit_expect(enc_r(FN_SRL, 3, 0, 1, 4), 3, 32'h0800000f);
        emit_expect(enc_r(FN_SRA, 4, 0, 1, 4), 4, 32'hf800000f);
        emit_expect(enc_i(OPC_ADDIU, 5, 0, 16'h0001), 5, 32'd1);
        emit_expect(enc_r(FN_SLT, 6, 1, 5, 0), 6, 32'd1);
        emit_expect(enc_r(FN_SLTU, 7, 1, 5, 0), 7, 32'd0);
        emit_expect(enc_r(FN_SLT, 8, 5, 1, 0), 8, 32'd0);
        emit_expect(enc_r(FN_SLTU, 9, 5, 1, 0), 9, 32'd1);
        emit_expect(enc_r(FN_SRA, 10, 0, 1, 31), 10, 32'hffffffff);
        emit_expect(enc_r(FN_SLL, 11, 0, 5, 31), 11, 32'h80000000);
        load_and_reset();
        collect_and_compare("shifts and compares");
    endtask

    task automatic test_branches();
        emit_expect(enc_i(OPC_ADDIU, 1, 0, 16'h0005), 1, 32'h5);
        emit_expect(enc_i(OPC_ADDIU, 2, 0, 16'h0005), 2, 32'h5);
        // taken, lands three words past the delay slot
        emit(enc_i(OPC_BEQ, 2, 1, 16'd3));
        emit_expect(enc_i(OPC_ADDIU, 3, 0, 16'h0033), 3, 32'h33);
        emit(enc_i(OPC_ADDIU, 4, 0, 16'h0044));
        emit(enc_i(OPC_ADDIU, 5, 0, 16'h0055));
        // equal operands, falls through
        emit(enc_i(OPC_BNE, 2, 1, 16'd4));
        emit_expect(enc_i(OPC_ADDIU, 6, 0, 16'h0066), 6, 32'h66);
        emit_expect(enc_i(OPC_ADDIU, 7, 0, 16'h0077), 7, 32'h77);
        emit(enc_i(OPC_BNE, 3, 1, 16'd2));
        emit_expect(enc_i(OPC_ADDIU, 8, 3, 16'h0001), 8, 32'h34);
        emit(enc_i(OPC_ADDIU, 9, 0, 16'h0099));
        emit_expect(enc_i(OPC_ADDIU, 10, 8, 16'h0002), 10, 32'h36);
        load_and_reset();
        collect_and_compare("branches");
    endtask

    task automatic test_reg_zero();
        emit_expect(enc_i(OPC_ADDIU, 1, 0, 16'h1234), 1, 32'h1234);
        emit(enc_i(OPC_ADDIU, 0, 1, 16'h0001));
        emit_expect(enc_r(FN_ADDU, 2, 0, 1, 0), 2, 32'h1234);
        // mult and lw are outside the core
        emit(enc_r(6'h18, 3, 1, 2, 0));
        emit(enc_i(6'h23, 4, 0, 16'h0000));
        emit_expect(enc_r(FN_OR, 5, 0, 0, 0), 5, 32'd0);
        emit_expect(enc_i(OPC_ADDIU, 6, 3, 16'h0001), 6, 32'd1);
        emit_expect(enc_i(OPC_ADDIU, 7, 4, 16'h0002), 7, 32'd2);
        load_and_reset();
        collect_and_compare("register zero and unknown encodings");
    endtask

    initial begin
        rst = 1'b1;
        test_reset();
        test_chains();
        test_immediates();
        test_shifts_compares();
        test_branches();
        test_reg_zero();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== mips_core.f ====
hw/mips_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_regfile.sv
hw/mips_execute.sv
hw/mips_result.sv
hw/mips_core.sv
test/tb_clock.sv
test/tb_imem.sv
test/tb_mips_core.sv
